//--- hw/alu.sv
`include "wasm_defs.svh"

module alu (
    input  wasm_isa_pkg::alu_op_t   i_op,
    input  logic [`WASM_WORD_W-1:0] i_top,
    input  logic [`WASM_WORD_W-1:0] i_second,
    input  logic [`WASM_WORD_W-1:0] i_const,
    output logic [`WASM_WORD_W-1:0] o_result
);
    import wasm_isa_pkg::*;

    // binary ops take second as the left operand
    always_comb begin
        case (i_op)
            ALU_ADD:     o_result = i_second + i_top;
            ALU_SUB:     o_result = i_second - i_top;
            ALU_MUL:     o_result = i_second * i_top;
            ALU_AND:     o_result = i_second & i_top;
            ALU_OR:      o_result = i_second | i_top;
            ALU_XOR:     o_result = i_second ^ i_top;
            ALU_SHL:     o_result = i_second << i_top[4:0];
            ALU_SHR_U:   o_result = i_second >> i_top[4:0];
            ALU_EQZ:     o_result = `WASM_WORD_W'(i_top == '0);
            ALU_EQ:      o_result = `WASM_WORD_W'(i_second == i_top);
            ALU_LT_U:    o_result = `WASM_WORD_W'(i_second < i_top);
            // byte addresses for the line memory
            ALU_LD_ADDR: o_result = i_top + i_const;
            ALU_ST_ADDR: o_result = i_second + i_const;
            default:     o_result = '0;
        endcase
    end

endmodule

//--- hw/ctrl_unit.sv
`include "wasm_defs.svh"

module ctrl_unit (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  wasm_isa_pkg::instr_word_t  i_instr,
    input  logic                       i_wr_vld,
    input  logic                       i_wr_finish,
    input  logic                       i_overflow,
    input  logic                       i_underflow,
    output logic                       o_wr_en,
    output logic                       o_wr_rdy,
    output wasm_core_pkg::work_state_t o_state,
    output logic                       o_shift_vld,
    output wasm_core_pkg::stack_ctrl_t o_stack_ctrl,
    output wasm_isa_pkg::alu_op_t      o_alu_op,
    output logic [`WASM_WORD_W-1:0]    o_const,
    output logic                       o_mem_rd,
    output logic                       o_mem_wr,
    output wasm_core_pkg::error_t      o_error
);
    import wasm_isa_pkg::*;
    import wasm_core_pkg::*;

    opcode_t opcode;
    logic    working;
    logic    binary;
    logic    is_load;
    logic    is_store;
    logic    is_end;
    logic    illegal;
    logic    bubble;
    logic    illegal_ev;
    logic    err_ev;

    assign opcode  = i_instr.c.opcode;
    assign working = (o_state == WORKING);

    always_comb begin
        o_stack_ctrl = '{pop_num: 2'd0, push: 1'b0, push_sel: PUSH_ALU};
        o_alu_op     = ALU_ADD;
        binary       = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        is_end       = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            OP_END:       is_end = 1'b1;
            OP_DROP:      o_stack_ctrl.pop_num = 2'd1;
            OP_I32_CONST: begin
                o_stack_ctrl.push     = 1'b1;
                o_stack_ctrl.push_sel = PUSH_CONST;
            end
            OP_I32_LOAD: begin
                o_stack_ctrl = '{pop_num: 2'd1, push: 1'b1, push_sel: PUSH_LOAD};
                o_alu_op     = ALU_LD_ADDR;
                is_load      = 1'b1;
            end
            OP_I32_STORE: begin
                o_stack_ctrl.pop_num = 2'd2;
                o_alu_op             = ALU_ST_ADDR;
                is_store             = 1'b1;
            end
            OP_I32_EQZ: begin
                o_stack_ctrl.pop_num = 2'd1;
                o_stack_ctrl.push    = 1'b1;
                o_alu_op             = ALU_EQZ;
            end
            OP_I32_EQ:    begin binary = 1'b1; o_alu_op = ALU_EQ;    end
            OP_I32_LT_U:  begin binary = 1'b1; o_alu_op = ALU_LT_U;  end
            OP_I32_ADD:   begin binary = 1'b1; o_alu_op = ALU_ADD;   end
            OP_I32_SUB:   begin binary = 1'b1; o_alu_op = ALU_SUB;   end
            OP_I32_MUL:   begin binary = 1'b1; o_alu_op = ALU_MUL;   end
            OP_I32_AND:   begin binary = 1'b1; o_alu_op = ALU_AND;   end
            OP_I32_OR:    begin binary = 1'b1; o_alu_op = ALU_OR;    end
            OP_I32_XOR:   begin binary = 1'b1; o_alu_op = ALU_XOR;   end
            OP_I32_SHL:   begin binary = 1'b1; o_alu_op = ALU_SHL;   end
            OP_I32_SHR_U: begin binary = 1'b1; o_alu_op = ALU_SHR_U; end
            default:      illegal = 1'b1;
        endcase
        if (binary) begin
            o_stack_ctrl.pop_num = 2'd2;
            o_stack_ctrl.push    = 1'b1;
        end
    end

    assign o_const = (opcode == OP_I32_CONST) ? i_instr.c.imm
                                              : `WASM_WORD_W'(i_instr.m.memarg.offset);

    // load: address cycle first, stack update on the bubble cycle
    assign o_mem_rd    = working && is_load && !bubble;
    assign o_shift_vld = working && !(is_load && !bubble);
    // a store that underflows must not reach memory
    assign o_mem_wr    = working && is_store && !i_underflow;

    assign illegal_ev = o_shift_vld && illegal;
    assign err_ev     = illegal_ev || i_overflow || i_underflow;
    assign o_wr_en    = i_wr_vld && o_wr_rdy;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state  <= INSTR_LOAD;
            o_wr_rdy <= 1'b1;
        end else begin
            case (o_state)
                INSTR_LOAD: begin
                    if (i_wr_finish) begin
                        o_state  <= WORKING;
                        o_wr_rdy <= 1'b0;
                    end
                end
                WORKING: begin
                    if ((o_shift_vld && is_end) || err_ev) begin
                        o_state <= FINISHED;
                    end
                end
                default: o_state <= o_state;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bubble  <= 1'b0;
            o_error <= '0;
        end else begin
            bubble             <= o_mem_rd;
            o_error.illegal_op <= o_error.illegal_op | illegal_ev;
            o_error.overflow   <= o_error.overflow | i_overflow;
            o_error.underflow  <= o_error.underflow | i_underflow;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_mem_rd && o_mem_wr)
    ) else $error("line memory read and write in the same cycle");

endmodule

//--- hw/instr_fetch.sv
`include "wasm_defs.svh"

module instr_fetch (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_wr_en,
    input  logic [`WASM_IMEM_AW-1:0]  i_wr_addr,
    input  wasm_isa_pkg::instr_word_t i_wr_data,
    input  logic                      i_shift_vld,
    output wasm_isa_pkg::instr_word_t o_instr
);
    import wasm_isa_pkg::*;

    localparam int DEPTH = 1 << `WASM_IMEM_AW;

    instr_word_t              mem [DEPTH];
    logic [`WASM_IMEM_AW-1:0] pc;

    // host write port, load phase only
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else if (i_shift_vld) begin
            pc <= pc + 1'b1;
        end
    end

    // current instruction, no read latency
    assign o_instr = mem[pc];

    // loading and executing never overlap
    a_no_wr_while_exec: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr_en && i_shift_vld)
    ) else $error("instruction write while executing");

endmodule

//--- hw/line_memory.sv
`include "wasm_defs.svh"

module line_memory (
    input  logic                       i_clk,
    input  wasm_core_pkg::work_state_t i_state,
    input  logic                       i_mem_rd,
    input  logic                       i_mem_wr,
    input  logic [`WASM_WORD_W-1:0]    i_addr,
    input  logic [`WASM_WORD_W-1:0]    i_wdata,
    input  logic                       i_rd_req,
    input  logic [`WASM_LMEM_AW-1:0]   i_rd_addr,
    output logic [`WASM_WORD_W-1:0]    o_load_data,
    output logic [`WASM_WORD_W-1:0]    o_rd_data
);
    import wasm_core_pkg::*;

    logic [`WASM_WORD_W-1:0]  mem [1 << `WASM_LMEM_AW];
    logic                     working;
    logic                     finished;
    logic                     rd_en;
    logic                     wr_en;
    logic [`WASM_LMEM_AW-1:0] addr;

    assign working  = (i_state == WORKING);
    assign finished = (i_state == FINISHED);
    assign rd_en    = (working && i_mem_rd) || (finished && i_rd_req);
    assign wr_en    = working && i_mem_wr;
    // host port owns the memory once execution is over
    assign addr     = finished ? i_rd_addr : i_addr[`WASM_LMEM_AW+1:2];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[addr] <= i_wdata;
        end
        if (rd_en) begin
            o_load_data <= mem[addr];
        end
    end

    assign o_rd_data = finished ? o_load_data : '0;

endmodule

//--- hw/operand_stack.sv
`include "wasm_defs.svh"

module operand_stack (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_shift_vld,
    input  wasm_core_pkg::stack_ctrl_t i_ctrl,
    input  logic [`WASM_WORD_W-1:0]    i_alu_result,
    input  logic [`WASM_WORD_W-1:0]    i_const,
    input  logic [`WASM_WORD_W-1:0]    i_load_data,
    output logic [`WASM_WORD_W-1:0]    o_top,
    output logic [`WASM_WORD_W-1:0]    o_second,
    output logic                       o_overflow,
    output logic                       o_underflow
);
    import wasm_core_pkg::*;

    localparam int AW = `WASM_ST_AW;

    logic [`WASM_WORD_W-1:0] mem [`WASM_ST_DEPTH];
    // number of live entries, 0 up to full depth
    logic [AW:0]             sp;
    logic [AW+1:0]           sp_next;
    logic [AW-1:0]           wr_idx;
    logic [`WASM_WORD_W-1:0] push_data;
    logic                    apply;

    // index wraps, so a full stack still finds its top at depth-1
    assign o_top    = mem[sp[AW-1:0] - AW'(1)];
    assign o_second = mem[sp[AW-1:0] - AW'(2)];

    assign sp_next = (AW+2)'(sp) + (AW+2)'(i_ctrl.push) - (AW+2)'(i_ctrl.pop_num);
    assign wr_idx  = sp[AW-1:0] - AW'(i_ctrl.pop_num);

    assign o_underflow = i_shift_vld && ((AW+1)'(i_ctrl.pop_num) > sp);
    assign o_overflow  = i_shift_vld && !o_underflow
                         && (sp_next > (AW+2)'(`WASM_ST_DEPTH));
    assign apply       = i_shift_vld && !o_underflow && !o_overflow;

    always_comb begin
        case (i_ctrl.push_sel)
            PUSH_CONST: push_data = i_const;
            PUSH_LOAD:  push_data = i_load_data;
            default:    push_data = i_alu_result;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sp <= '0;
        end else if (apply) begin
            sp <= sp_next[AW:0];
        end
    end

    // pop then push, the new word lands where the popped ones were
    always_ff @(posedge i_clk) begin
        if (apply && i_ctrl.push) begin
            mem[wr_idx] <= push_data;
        end
    end

    a_sp_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        sp <= (AW+1)'(`WASM_ST_DEPTH)
    ) else $error("stack pointer beyond depth");

endmodule

//--- hw/wasm_core_pkg.sv
package wasm_core_pkg;

    typedef enum logic [1:0] {
        INSTR_LOAD = 2'b00,
        WORKING    = 2'b01,
        FINISHED   = 2'b11
    } work_state_t;

    // sticky flags, reported as one word
    typedef struct packed {
        logic illegal_op;
        logic overflow;
        logic underflow;
    } error_t;

    typedef enum logic [1:0] {
        PUSH_ALU   = 2'd0,
        PUSH_CONST = 2'd1,
        PUSH_LOAD  = 2'd2
    } push_sel_t;

    // pop first, then push at most one word
    typedef struct packed {
        logic [1:0] pop_num;
        logic       push;
        push_sel_t  push_sel;
    } stack_ctrl_t;

endpackage

//--- hw/wasm_defs.svh
`ifndef WASM_DEFS_SVH
`define WASM_DEFS_SVH

// data path word
`define WASM_WORD_W 32

// instruction memory, 256 words
`define WASM_IMEM_AW 8

// operand stack
`define WASM_ST_DEPTH 64
`define WASM_ST_AW 6

// line memory word address, 1024 words
`define WASM_LMEM_AW 10

`endif

//--- hw/wasm_isa_pkg.sv
`include "wasm_defs.svh"

package wasm_isa_pkg;

    typedef logic [7:0] opcode_t;

    localparam opcode_t OP_END       = 8'h0b;
    localparam opcode_t OP_DROP      = 8'h1a;
    localparam opcode_t OP_I32_LOAD  = 8'h28;
    localparam opcode_t OP_I32_STORE = 8'h36;
    localparam opcode_t OP_I32_CONST = 8'h41;
    localparam opcode_t OP_I32_EQZ   = 8'h45;
    localparam opcode_t OP_I32_EQ    = 8'h46;
    localparam opcode_t OP_I32_LT_U  = 8'h49;
    localparam opcode_t OP_I32_ADD   = 8'h6a;
    localparam opcode_t OP_I32_SUB   = 8'h6b;
    localparam opcode_t OP_I32_MUL   = 8'h6c;
    localparam opcode_t OP_I32_AND   = 8'h71;
    localparam opcode_t OP_I32_OR    = 8'h72;
    localparam opcode_t OP_I32_XOR   = 8'h73;
    localparam opcode_t OP_I32_SHL   = 8'h74;
    localparam opcode_t OP_I32_SHR_U = 8'h76;

    // align is carried but not used
    typedef struct packed {
        logic [7:0]  align;
        logic [23:0] offset;
    } memarg_t;

    typedef struct packed {
        logic [`WASM_WORD_W-1:0] imm;
        opcode_t                 opcode;
    } const_fmt_t;

    typedef struct packed {
        memarg_t memarg;
        opcode_t opcode;
    } mem_fmt_t;

    // same 40 bits, read as const or as load/store
    typedef union packed {
        const_fmt_t c;
        mem_fmt_t   m;
    } instr_word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR_U,
        ALU_EQZ,
        ALU_EQ,
        ALU_LT_U,
        ALU_LD_ADDR,
        ALU_ST_ADDR
    } alu_op_t;

endpackage

//--- hw/wasm_top.sv
`include "wasm_defs.svh"

module wasm_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    output logic                       o_instr_mem_wr_rdy,
    input  logic                       i_instr_mem_wr_vld,
    input  logic [`WASM_IMEM_AW-1:0]   i_instr_mem_wr_addr,
    input  wasm_isa_pkg::instr_word_t  i_instr_mem_wr_data,
    input  logic                       i_instr_mem_wr_finish,
    input  logic                       i_line_mem_rd_req,
    input  logic [`WASM_LMEM_AW-1:0]   i_line_mem_rd_addr,
    output logic [`WASM_WORD_W-1:0]    o_line_mem_rd_data,
    output wasm_core_pkg::work_state_t o_work_state,
    output wasm_core_pkg::error_t      o_error
);
    import wasm_isa_pkg::*;
    import wasm_core_pkg::*;

    instr_word_t             instr;
    work_state_t             state;
    stack_ctrl_t             stack_ctrl;
    alu_op_t                 alu_op;
    logic                    wr_en;
    logic                    shift_vld;
    logic                    overflow;
    logic                    underflow;
    logic                    mem_rd;
    logic                    mem_wr;
    logic [`WASM_WORD_W-1:0] const_val;
    logic [`WASM_WORD_W-1:0] top;
    logic [`WASM_WORD_W-1:0] second;
    logic [`WASM_WORD_W-1:0] alu_result;
    logic [`WASM_WORD_W-1:0] load_data;

    assign o_work_state = state;

    instr_fetch u_instr_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_en     (wr_en),
        .i_wr_addr   (i_instr_mem_wr_addr),
        .i_wr_data   (i_instr_mem_wr_data),
        .i_shift_vld (shift_vld),
        .o_instr     (instr)
    );

    ctrl_unit u_ctrl_unit (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_instr      (instr),
        .i_wr_vld     (i_instr_mem_wr_vld),
        .i_wr_finish  (i_instr_mem_wr_finish),
        .i_overflow   (overflow),
        .i_underflow  (underflow),
        .o_wr_en      (wr_en),
        .o_wr_rdy     (o_instr_mem_wr_rdy),
        .o_state      (state),
        .o_shift_vld  (shift_vld),
        .o_stack_ctrl (stack_ctrl),
        .o_alu_op     (alu_op),
        .o_const      (const_val),
        .o_mem_rd     (mem_rd),
        .o_mem_wr     (mem_wr),
        .o_error      (o_error)
    );

    operand_stack u_operand_stack (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_shift_vld  (shift_vld),
        .i_ctrl       (stack_ctrl),
        .i_alu_result (alu_result),
        .i_const      (const_val),
        .i_load_data  (load_data),
        .o_top        (top),
        .o_second     (second),
        .o_overflow   (overflow),
        .o_underflow  (underflow)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_top    (top),
        .i_second (second),
        .i_const  (const_val),
        .o_result (alu_result)
    );

    // store data is always the top word
    line_memory u_line_memory (
        .i_clk       (i_clk),
        .i_state     (state),
        .i_mem_rd    (mem_rd),
        .i_mem_wr    (mem_wr),
        .i_addr      (alu_result),
        .i_wdata     (top),
        .i_rd_req    (i_line_mem_rd_req),
        .i_rd_addr   (i_line_mem_rd_addr),
        .o_load_data (load_data),
        .o_rd_data   (o_line_mem_rd_data)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run the testbench, result taken from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module wasm_top_tb \
    -Mdir obj_dir -o wasm_top_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/wasm_top_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+hw
hw/wasm_isa_pkg.sv
hw/wasm_core_pkg.sv
hw/instr_fetch.sv
hw/ctrl_unit.sv
hw/operand_stack.sv
hw/alu.sv
hw/line_memory.sv
hw/wasm_top.sv
verification/wasm_top_tb.sv

//--- verification/wasm_top_tb.sv
`include "wasm_defs.svh"

module wasm_top_tb;
    import wasm_isa_pkg::*;
    import wasm_core_pkg::*;

    // six tests of roughly 300 cycles each plus a wide margin
    localparam int NUM_TESTS  = 6;
    localparam int MAX_CYCLES = 20000;

    logic                     clk;
    logic                     rst_n;
    logic                     wr_rdy;
    logic                     wr_vld;
    logic [`WASM_IMEM_AW-1:0] wr_addr;
    instr_word_t              wr_data;
    logic                     wr_finish;
    logic                     rd_req;
    logic [`WASM_LMEM_AW-1:0] rd_addr;
    logic [`WASM_WORD_W-1:0]  rd_data;
    work_state_t              work_state;
    error_t                   error;

    instr_word_t prog [$];
    logic [31:0] rng_state = 32'heb0a_4011;
    string       cur_test;
    int          err_count = 0;
    int          err_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    wasm_top dut (
        .i_clk                 (clk),
        .i_rst_n               (rst_n),
        .o_instr_mem_wr_rdy    (wr_rdy),
        .i_instr_mem_wr_vld    (wr_vld),
        .i_instr_mem_wr_addr   (wr_addr),
        .i_instr_mem_wr_data   (wr_data),
        .i_instr_mem_wr_finish (wr_finish),
        .i_line_mem_rd_req     (rd_req),
        .i_line_mem_rd_addr    (rd_addr),
        .o_line_mem_rd_data    (rd_data),
        .o_work_state          (work_state),
        .o_error               (error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run passed %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected value of (a op b)
    // eqz looks at a only
    function automatic logic [31:0] model_op(opcode_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_I32_ADD:   return a + b;
            OP_I32_SUB:   return a - b;
            OP_I32_MUL:   return a * b;
            OP_I32_AND:   return a & b;
            OP_I32_OR:    return a | b;
            OP_I32_XOR:   return a ^ b;
            OP_I32_SHL:   return a << b[4:0];
            OP_I32_SHR_U: return a >> b[4:0];
            OP_I32_EQ:    return {31'd0, a == b};
            OP_I32_LT_U:  return {31'd0, a < b};
            OP_I32_EQZ:   return {31'd0, a == 32'd0};
            default:      return 32'd0;
        endcase
    endfunction

    function automatic logic [`WASM_LMEM_AW-1:0] word_addr(logic [31:0] byte_addr);
        return byte_addr[`WASM_LMEM_AW+1:2];
    endfunction

    task automatic emit_op(input opcode_t op);
        instr_word_t w;
        w = '0;
        w.c.opcode = op;
        prog.push_back(w);
    endtask

    task automatic emit_const(input logic [31:0] value);
        instr_word_t w;
        w.c.imm = value;
        w.c.opcode = OP_I32_CONST;
        prog.push_back(w);
    endtask

    task automatic emit_mem(input opcode_t op, input logic [23:0] offset);
        instr_word_t w;
        w.m.memarg.align = 8'd2;
        w.m.memarg.offset = offset;
        w.m.opcode = op;
        prog.push_back(w);
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch in %s (%s): expected 0x%08h, actual 0x%08h",
                     cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_state(input work_state_t exp, input work_state_t act);
        if (act !== exp) begin
            $display("mismatch in %s (state): expected %b, actual %b", cur_test, exp, act);
            err_count++;
        end
    endtask

    // bits are illegal_op, overflow, underflow
    task automatic check_error(input error_t exp, input error_t act);
        if (act !== exp) begin
            $display("mismatch in %s (error): expected %b, actual %b", cur_test, exp, act);
            err_count++;
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_at_start = err_count;
        prog.delete();
        reset_dut();
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == err_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", cur_test, err_count - err_at_start);
        end
    endtask

    // write the program, pulse finish, wait until execution stops
    task automatic run_program();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            wr_vld = 1'b1;
            wr_addr = `WASM_IMEM_AW'(i);
            wr_data = prog[i];
        end
        @(negedge clk);
        wr_vld = 1'b0;
        wr_finish = 1'b1;
        @(negedge clk);
        wr_finish = 1'b0;
        while (work_state == WORKING) begin
            @(negedge clk);
        end
    endtask

    task automatic check_line(input logic [`WASM_LMEM_AW-1:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        @(negedge clk);
        rd_req = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_req = 1'b0;
        @(negedge clk);
        data = rd_data;
        check_word($sformatf("line word 0x%03h", addr), exp, data);
    endtask

    task automatic reset_and_end();
        begin_test("reset");
        check_word("rdy after reset", 32'd1, 32'(wr_rdy));
        check_state(INSTR_LOAD, work_state);
        check_error('0, error);
        emit_op(OP_END);
        run_program();
        check_word("rdy after finish", 32'd0, 32'(wr_rdy));
        check_state(FINISHED, work_state);
        check_error('0, error);
        end_test();
    endtask

    task automatic arith_ops();
        opcode_t     ops [13];
        logic [31:0] exp [13];
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        begin_test("arith");
        ops = '{OP_I32_ADD, OP_I32_SUB, OP_I32_MUL, OP_I32_AND, OP_I32_OR, OP_I32_XOR,
                OP_I32_SHL, OP_I32_SHR_U, OP_I32_EQ, OP_I32_LT_U, OP_I32_EQ,
                OP_I32_EQZ, OP_I32_EQZ};
        for (i = 0; i < 13; i++) begin
            a = xorshift32();
            b = xorshift32();
            // equal operands and a zero operand hit the true side of the compares
            if (i == 10) begin
                b = a;
            end
            if (i == 12) begin
                a = 32'd0;
            end
            exp[i] = model_op(ops[i], a, b);
            emit_const(32'h40 + 32'(4 * i));
            emit_const(a);
            if (ops[i] != OP_I32_EQZ) begin
                emit_const(b);
            end
            emit_op(ops[i]);
            emit_mem(OP_I32_STORE, 24'h0);
        end
        emit_op(OP_END);
        run_program();
        check_state(FINISHED, work_state);
        check_error('0, error);
        for (i = 0; i < 13; i++) begin
            check_line(word_addr(32'h40 + 32'(4 * i)), exp[i]);
        end
        end_test();
    endtask

    task automatic load_store_offsets();
        logic [31:0] v [3];
        int          i;
        begin_test("load_store");
        for (i = 0; i < 3; i++) begin
            v[i] = xorshift32();
            emit_const(32'h100);
            emit_const(v[i]);
            emit_mem(OP_I32_STORE, 24'h40 + 24'(4 * i));
        end
        // load each word back and store a copy at a second base
        for (i = 0; i < 3; i++) begin
            emit_const(32'h120);
            emit_const(32'h100);
            emit_mem(OP_I32_LOAD, 24'h40 + 24'(4 * i));
            if (i == 2) begin
                emit_const(xorshift32());
                emit_op(OP_DROP);
            end
            emit_mem(OP_I32_STORE, 24'h80 + 24'(4 * i));
        end
        emit_op(OP_END);
        run_program();
        check_state(FINISHED, work_state);
        check_error('0, error);
        for (i = 0; i < 3; i++) begin
            check_line(word_addr(32'h140 + 32'(4 * i)), v[i]);
            check_line(word_addr(32'h1a0 + 32'(4 * i)), v[i]);
        end
        end_test();
    endtask

    task automatic stack_underflow();
        logic [31:0] v;
        error_t      exp_err;
        begin_test("underflow");
        v = xorshift32();
        emit_const(32'h200);
        emit_const(v);
        emit_mem(OP_I32_STORE, 24'h0);
        emit_op(OP_I32_ADD);
        emit_op(OP_END);
        run_program();
        exp_err = '0;
        exp_err.underflow = 1'b1;
        check_state(FINISHED, work_state);
        check_error(exp_err, error);
        check_line(word_addr(32'h200), v);
        end_test();
    endtask

    task automatic stack_overflow();
        error_t exp_err;
        int     i;
        begin_test("overflow");
        for (i = 0; i < `WASM_ST_DEPTH + 1; i++) begin
            emit_const(xorshift32());
        end
        emit_op(OP_END);
        run_program();
        exp_err = '0;
        exp_err.overflow = 1'b1;
        check_state(FINISHED, work_state);
        check_error(exp_err, error);
        end_test();
    endtask

    task automatic illegal_opcode();
        error_t exp_err;
        begin_test("illegal_op");
        // memory keeps its contents across resets so the target word is cleared first
        emit_const(32'h300);
        emit_const(32'h0);
        emit_mem(OP_I32_STORE, 24'h0);
        emit_op(8'hff);
        emit_const(32'h300);
        emit_const(xorshift32() | 32'h1);
        emit_mem(OP_I32_STORE, 24'h0);
        emit_op(OP_END);
        run_program();
        exp_err = '0;
        exp_err.illegal_op = 1'b1;
        check_state(FINISHED, work_state);
        check_error(exp_err, error);
        check_line(word_addr(32'h300), 32'h0);
        end_test();
    endtask

    initial begin
        rst_n = 1'b0;
        wr_vld = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_finish = 1'b0;
        rd_req = 1'b0;
        rd_addr = '0;
        reset_and_end();
        arith_ops();
        load_store_offsets();
        stack_underflow();
        stack_overflow();
        illegal_opcode();
        $display("tests run %0d of %0d, tests failed %0d, checks failed %0d",
                 tests_run, NUM_TESTS, tests_failed, err_count);
        if (err_count == 0 && tests_run == NUM_TESTS) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
